// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsCoreTb
FILELIST  = mipsCore.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mipsCore.f
+incdir+source
source/isaPkg.sv
source/datapathPkg.sv
source/controlUnit.sv
source/fetchUnit.sv
source/executeUnit.sv
source/dataMemory.sv
source/mipsCore.sv
verif/mipsCoreTb.sv

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import isaPkg::*, datapathPkg::*; (
	input  opcode_t opcode,
	input  funct_t  funct,
	input  logic    equal,
	output logic    pcSrc,
	output logic    jumpReg,
	output logic    jumpType,
	output aluOp_t  aluOp,
	output logic    aluSrc,
	output logic    extOp,
	output logic    upperImm,
	output logic    regZero,
	output logic    regDst,
	output logic    regWriteEnable,
	output logic    memWrite,
	output logic    memRead,
	output logic    memToReg,
	output logic    halt
);

	always_comb begin
		pcSrc          = 1'b0;
		jumpReg        = 1'b0;
		jumpType       = 1'b0;
		aluOp          = ALU_SLL;
		aluSrc         = 1'b0;
		// sign extension unless told otherwise
		extOp          = 1'b1;
		upperImm       = 1'b0;
		regZero        = 1'b0;
		regDst         = 1'b0;
		regWriteEnable = 1'b0;
		memWrite       = 1'b0;
		memRead        = 1'b0;
		memToReg       = 1'b0;
		halt           = 1'b0;

		if (opcode == RTYPE) begin
			// rd is the destination
			regDst = 1'b1;
			case (funct)
				SLLV: aluOp = ALU_SLL;
				SRLV: aluOp = ALU_SRL;
				ADD, ADDU: aluOp = ALU_ADD;
				SUB, SUBU: aluOp = ALU_SUB;
				AND: aluOp = ALU_AND;
				OR: aluOp = ALU_OR;
				XOR: aluOp = ALU_XOR;
				NOR: aluOp = ALU_NOR;
				SLT: aluOp = ALU_SLT;
				SLTU: aluOp = ALU_SLTU;
				default: aluOp = ALU_SLL;
			endcase
			// everything but jr writes rd, unknown codes do nothing
			regWriteEnable = (funct inside {SLLV, SRLV, ADD, ADDU, SUB, SUBU,
				AND, OR, XOR, NOR, SLT, SLTU});
			jumpReg = (funct == JR);
		end else begin
			case (opcode)
				J: jumpType = 1'b1;
				JAL: begin
					// link goes to r31, picked in execute
					jumpType       = 1'b1;
					regWriteEnable = 1'b1;
				end
				BEQ: begin
					aluOp = ALU_SUB;
					pcSrc = equal;
				end
				BNE: begin
					aluOp = ALU_SUB;
					pcSrc = !equal;
				end
				ADDI, ADDIU: begin
					aluOp          = ALU_ADD;
					aluSrc         = 1'b1;
					regWriteEnable = 1'b1;
				end
				SLTI: begin
					aluOp          = ALU_SLT;
					aluSrc         = 1'b1;
					regWriteEnable = 1'b1;
				end
				SLTIU: begin
					aluOp          = ALU_SLTU;
					aluSrc         = 1'b1;
					regWriteEnable = 1'b1;
				end
				ANDI, ORI, XORI: begin
					aluOp          = (opcode == ANDI) ? ALU_AND :
						(opcode == ORI) ? ALU_OR : ALU_XOR;
					aluSrc         = 1'b1;
					extOp          = 1'b0;
					regWriteEnable = 1'b1;
				end
				LUI: begin
					// zero | (imm << 16)
					aluOp          = ALU_OR;
					aluSrc         = 1'b1;
					upperImm       = 1'b1;
					regZero        = 1'b1;
					regWriteEnable = 1'b1;
				end
				LW: begin
					aluOp          = ALU_ADD;
					aluSrc         = 1'b1;
					regWriteEnable = 1'b1;
					memRead        = 1'b1;
					memToReg       = 1'b1;
				end
				SW: begin
					aluOp    = ALU_ADD;
					aluSrc   = 1'b1;
					memWrite = 1'b1;
				end
				HALT: halt = 1'b1;
				default: halt = 1'b0;
			endcase
		end
	end

	// a store never writes back
	always_comb begin
		assert (!(memWrite && regWriteEnable))
			else $error("store decoded with register write enabled");
	end

endmodule

// File: source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and instruction width
`define WORD_W 32

// depths in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`define REG_COUNT 32

`endif

// File: source/dataMemory.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module dataMemory import datapathPkg::*; (
	input  logic  CLK,
	input  logic  reset,
	input  logic  memWrite,
	input  logic  memRead,
	input  word_t aluResult,
	input  word_t rtValue,
	output word_t loadValue,
	output logic  storeValid,
	output word_t storeAddr,
	output word_t storeData
);

	localparam int D_IDX_W = $clog2(`DMEM_DEPTH);

	word_t              mem [`DMEM_DEPTH];
	logic [D_IDX_W-1:0] addrIdx;

	// word addressed
	assign addrIdx   = aluResult[D_IDX_W-1:0];
	assign loadValue = memRead ? mem[addrIdx] : '0;

	always_ff @(posedge CLK) begin
		if (reset) begin
			storeValid <= 1'b0;
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			storeValid <= memWrite;
			if (memWrite) begin
				mem[addrIdx] <= rtValue;
			end
		end
	end

	// store report, qualified by storeValid
	always_ff @(posedge CLK) begin
		if (memWrite) begin
			storeAddr <= aluResult;
			storeData <= rtValue;
		end
	end

endmodule

// File: source/datapathPkg.sv
`include "cpu_defines.svh"

package datapathPkg;

	typedef logic [`WORD_W-1:0] word_t;

	typedef enum logic [3:0] {
		ALU_SLL,
		ALU_SRL,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU
	} aluOp_t;

	typedef enum logic {
		FETCH_RUN,
		FETCH_HALTED
	} fetchState_t;

endpackage

// File: source/executeUnit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeUnit import isaPkg::*, datapathPkg::*; (
	input  logic   CLK,
	input  logic   reset,
	input  word_t  instr,
	input  word_t  pcPlusOne,
	input  aluOp_t aluOp,
	input  logic   aluSrc,
	input  logic   extOp,
	input  logic   upperImm,
	input  logic   regZero,
	input  logic   regDst,
	input  logic   regWriteEnable,
	input  logic   memToReg,
	input  logic   jumpType,
	input  word_t  loadValue,
	output word_t  aluResult,
	output word_t  rsValue,
	output word_t  rtValue,
	output logic   equal
);

	word_t            regFile [`REG_COUNT];
	regIndex_t        rsIdx;
	regIndex_t        rtIdx;
	regIndex_t        rdIdx;
	regIndex_t        wrIdx;
	logic [IMM_W-1:0] imm;
	word_t            extImm;
	word_t            opA;
	word_t            opB;
	word_t            wrData;
	logic             linkWrite;

	assign rsIdx = instr[IMM_W+2*REG_W-1 -: REG_W];
	assign rtIdx = instr[IMM_W+REG_W-1 -: REG_W];
	assign rdIdx = instr[IMM_W-1 -: REG_W];
	assign imm   = instr[IMM_W-1:0];

	assign rsValue = regFile[rsIdx];
	assign rtValue = regFile[rtIdx];
	assign equal   = (rsValue == rtValue);

	always_comb begin
		if (upperImm) begin
			extImm = {imm, {(`WORD_W-IMM_W){1'b0}}};
		end else if (extOp) begin
			extImm = {{(`WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
		end else begin
			extImm = {{(`WORD_W-IMM_W){1'b0}}, imm};
		end
	end

	assign opA = regZero ? '0 : rsValue;
	assign opB = aluSrc ? extImm : rtValue;

	// shift amount comes from rs, the shifted value from rt
	always_comb begin
		case (aluOp)
			ALU_SLL:  aluResult = opB << opA[4:0];
			ALU_SRL:  aluResult = opB >> opA[4:0];
			ALU_ADD:  aluResult = opA + opB;
			ALU_SUB:  aluResult = opA - opB;
			ALU_AND:  aluResult = opA & opB;
			ALU_OR:   aluResult = opA | opB;
			ALU_XOR:  aluResult = opA ^ opB;
			ALU_NOR:  aluResult = ~(opA | opB);
			ALU_SLT:  aluResult = word_t'($signed(opA) < $signed(opB));
			ALU_SLTU: aluResult = word_t'(opA < opB);
			default:  aluResult = '0;
		endcase
	end

	// jal links into r31
	assign linkWrite = jumpType && regWriteEnable;
	assign wrIdx  = linkWrite ? regIndex_t'(`REG_COUNT - 1) : (regDst ? rdIdx : rtIdx);
	assign wrData = linkWrite ? pcPlusOne : (memToReg ? loadValue : aluResult);

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (regWriteEnable && wrIdx != '0) begin
			regFile[wrIdx] <= wrData;
		end
	end

	assert property (@(posedge CLK) disable iff (reset)
		(rsIdx == '0) |-> (rsValue == '0))
		else $error("register 0 holds a nonzero value");

endmodule

// File: source/fetchUnit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetchUnit import isaPkg::*, datapathPkg::*; (
	input  logic  CLK,
	input  logic  reset,
	input  logic  loadEnable,
	input  word_t loadAddr,
	input  word_t loadData,
	input  logic  pcSrc,
	input  logic  jumpReg,
	input  logic  jumpType,
	input  logic  halt,
	input  word_t rsValue,
	output word_t instr,
	output word_t pcPlusOne,
	output logic  halted,
	output word_t haltPc
);

	localparam int PC_IDX_W = $clog2(`IMEM_DEPTH);

	word_t       imem [`IMEM_DEPTH];
	word_t       pc;
	word_t       nextPc;
	word_t       branchOffset;
	fetchState_t state;

	// program load port
	always_ff @(posedge CLK) begin
		if (loadEnable) begin
			imem[loadAddr[PC_IDX_W-1:0]] <= loadData;
		end
	end

	// all zero word decodes to nothing once halted
	assign instr     = (state == FETCH_HALTED) ? '0 : imem[pc[PC_IDX_W-1:0]];
	assign halted    = (state == FETCH_HALTED);
	assign pcPlusOne = pc + 1;

	assign branchOffset = {{(`WORD_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};

	always_comb begin
		if (jumpType) begin
			nextPc = {{(`WORD_W-TARGET_W){1'b0}}, instr[TARGET_W-1:0]};
		end else if (jumpReg) begin
			nextPc = rsValue;
		end else if (pcSrc) begin
			nextPc = pcPlusOne + branchOffset;
		end else begin
			nextPc = pcPlusOne;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= FETCH_RUN;
			pc    <= '0;
		end else if (state == FETCH_RUN) begin
			if (halt) begin
				state <= FETCH_HALTED;
			end else begin
				pc <= nextPc;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (state == FETCH_RUN && halt) begin
			haltPc <= pc;
		end
	end

	// jumps and branches must land inside instruction memory
	assert property (@(posedge CLK) disable iff (reset)
		(state == FETCH_RUN) |-> (pc < `IMEM_DEPTH))
		else $error("pc %0d left instruction memory", pc);

endmodule

// File: source/isaPkg.sv
package isaPkg;

	// instruction field widths
	localparam int OPCODE_W = 6;
	localparam int FUNCT_W  = 6;
	localparam int REG_W    = 5;
	localparam int IMM_W    = 16;
	localparam int TARGET_W = 26;

	typedef logic [REG_W-1:0] regIndex_t;

	// standard mips major opcodes, halt is all ones
	typedef enum logic [OPCODE_W-1:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		ADDIU = 6'h09,
		SLTI  = 6'h0A,
		SLTIU = 6'h0B,
		ANDI  = 6'h0C,
		ORI   = 6'h0D,
		XORI  = 6'h0E,
		LUI   = 6'h0F,
		LW    = 6'h23,
		SW    = 6'h2B,
		HALT  = 6'h3F
	} opcode_t;

	// function codes for rtype
	typedef enum logic [FUNCT_W-1:0] {
		SLLV = 6'h04,
		SRLV = 6'h06,
		JR   = 6'h08,
		ADD  = 6'h20,
		ADDU = 6'h21,
		SUB  = 6'h22,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2A,
		SLTU = 6'h2B
	} funct_t;

endpackage

// File: source/mipsCore.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mipsCore import isaPkg::*, datapathPkg::*; (
	input  logic  CLK,
	input  logic  reset,
	input  logic  loadEnable,
	input  word_t loadAddr,
	input  word_t loadData,
	output logic  storeValid,
	output word_t storeAddr,
	output word_t storeData,
	output logic  halted,
	output word_t haltPc
);

	word_t   instr;
	word_t   pcPlusOne;
	word_t   aluResult;
	word_t   rsValue;
	word_t   rtValue;
	word_t   loadValue;
	opcode_t opcode;
	funct_t  funct;
	aluOp_t  aluOp;
	logic    equal;
	logic    pcSrc;
	logic    jumpReg;
	logic    jumpType;
	logic    aluSrc;
	logic    extOp;
	logic    upperImm;
	logic    regZero;
	logic    regDst;
	logic    regWriteEnable;
	logic    memWrite;
	logic    memRead;
	logic    memToReg;
	logic    halt;

	assign opcode = opcode_t'(instr[`WORD_W-1 -: OPCODE_W]);
	assign funct  = funct_t'(instr[FUNCT_W-1:0]);

	fetchUnit u_fetchUnit (
		.CLK(CLK), .reset(reset),
		.loadEnable(loadEnable), .loadAddr(loadAddr), .loadData(loadData),
		.pcSrc(pcSrc), .jumpReg(jumpReg), .jumpType(jumpType), .halt(halt),
		.rsValue(rsValue), .instr(instr), .pcPlusOne(pcPlusOne),
		.halted(halted), .haltPc(haltPc)
	);

	controlUnit u_controlUnit (
		.opcode(opcode), .funct(funct), .equal(equal),
		.pcSrc(pcSrc), .jumpReg(jumpReg), .jumpType(jumpType), .aluOp(aluOp),
		.aluSrc(aluSrc), .extOp(extOp), .upperImm(upperImm), .regZero(regZero),
		.regDst(regDst), .regWriteEnable(regWriteEnable), .memWrite(memWrite),
		.memRead(memRead), .memToReg(memToReg), .halt(halt)
	);

	executeUnit u_executeUnit (
		.CLK(CLK), .reset(reset), .instr(instr), .pcPlusOne(pcPlusOne),
		.aluOp(aluOp), .aluSrc(aluSrc), .extOp(extOp), .upperImm(upperImm),
		.regZero(regZero), .regDst(regDst), .regWriteEnable(regWriteEnable),
		.memToReg(memToReg), .jumpType(jumpType), .loadValue(loadValue),
		.aluResult(aluResult), .rsValue(rsValue), .rtValue(rtValue), .equal(equal)
	);

	dataMemory u_dataMemory (
		.CLK(CLK), .reset(reset), .memWrite(memWrite), .memRead(memRead),
		.aluResult(aluResult), .rtValue(rtValue), .loadValue(loadValue),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
	);

endmodule

// File: verif/mipsCoreTb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mipsCoreTb import datapathPkg::*; ();

	localparam int PERIOD_NS      = 40;
	localparam int DRIVE_DELAY_NS = 2;
	localparam int RESET_CYCLES   = 16;
	localparam int TAIL_CYCLES    = 4;
	// program load and reset plus four passes over instruction memory and a tail
	localparam int WATCHDOG_CYCLES = `IMEM_DEPTH + RESET_CYCLES + 4 * `IMEM_DEPTH + TAIL_CYCLES;

	logic  CLK;
	logic  reset;
	logic  loadEnable;
	word_t loadAddr;
	word_t loadData;
	logic  storeValid;
	word_t storeAddr;
	word_t storeData;
	logic  halted;
	word_t haltPc;

	// expected stores in program order
	word_t expAddrQ [$];
	word_t expDataQ [$];
	word_t expHaltPc;
	logic  haltExpected;
	logic  haltSeen;
	int    storeCount;

	mipsCore u_mipsCore (
		.CLK(CLK),
		.reset(reset),
		.loadEnable(loadEnable),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted),
		.haltPc(haltPc)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkStore(input word_t address, input word_t data);
		word_t expAddr;
		word_t expData;
		if (expAddrQ.size() == 0) begin
			abortRun($sformatf("store of %h to address %h at time %0t was not expected",
				data, address, $time));
		end else begin
			expAddr = expAddrQ.pop_front();
			expData = expDataQ.pop_front();
			if (address !== expAddr) begin
				abortRun($sformatf(
					"mismatch at time %0t: store %0d address expected %h, actual %h",
					$time, storeCount, expAddr, address));
			end else if (data !== expData) begin
				abortRun($sformatf(
					"mismatch at time %0t: store %0d data expected %h, actual %h",
					$time, storeCount, expData, data));
			end else begin
				storeCount++;
			end
		end
	endtask

	task automatic checkHalt(input word_t pc);
		if (pc !== expHaltPc) begin
			abortRun($sformatf("mismatch at time %0t: halt address expected %h, actual %h",
				$time, expHaltPc, pc));
		end else if (expAddrQ.size() != 0) begin
			abortRun($sformatf("core halted with %0d expected stores never seen",
				expAddrQ.size()));
		end
	endtask

	// P lines go to the load port one word per clock
	task automatic loadProgram();
		int         fd;
		int         c;
		int         n;
		logic [7:0] ch;
		word_t      a;
		word_t      d;
		string      problem;
		problem = "";
		fd = $fopen("verif/program_input.txt", "r");
		if (fd == 0) begin
			abortRun("cannot open the stimulus file verif/program_input.txt");
		end else begin
			c = $fgetc(fd);
			while (c != -1 && problem.len() == 0) begin
				ch = c[7:0];
				if (ch == "#") begin
					// rest of the line is a comment
					while (c != -1 && c != 10) begin
						c = $fgetc(fd);
					end
				end else if (ch == "P") begin
					n = $fscanf(fd, "%h %h", a, d);
					if (n != 2) begin
						problem = "a program line in the stimulus file is malformed";
					end
					@(posedge CLK);
					#(DRIVE_DELAY_NS);
					loadEnable = 1'b1;
					loadAddr   = a;
					loadData   = d;
				end else if (ch == "S") begin
					n = $fscanf(fd, "%h %h", a, d);
					if (n != 2) begin
						problem = "a store line in the stimulus file is malformed";
					end
					expAddrQ.push_back(a);
					expDataQ.push_back(d);
				end else if (ch == "H") begin
					n = $fscanf(fd, "%h", a);
					if (n != 1) begin
						problem = "the halt line in the stimulus file is malformed";
					end
					expHaltPc    = a;
					haltExpected = 1'b1;
				end
				if (c != -1) begin
					c = $fgetc(fd);
				end
			end
			$fclose(fd);
			if (problem.len() != 0) begin
				abortRun(problem);
			end else if (!haltExpected) begin
				abortRun("the stimulus file gives no expected halt address");
			end
		end
	endtask

	initial begin
		reset        = 1'b1;
		loadEnable   = 1'b0;
		loadAddr     = '0;
		loadData     = '0;
		expHaltPc    = '0;
		haltExpected = 1'b0;
		haltSeen     = 1'b0;
		storeCount   = 0;

		loadProgram();
		@(posedge CLK);
		#(DRIVE_DELAY_NS);
		loadEnable = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#(DRIVE_DELAY_NS);
		reset = 1'b0;

		wait (haltSeen);
		// nothing may be stored once halted
		repeat (TAIL_CYCLES) @(posedge CLK);
		$display("%0d stores checked, core halted at word %0d", storeCount, haltPc);
		$display("SIMULATION PASSED");
		$finish;
	end

	// outputs are stable at the falling edge
	initial begin
		forever begin
			@(negedge CLK);
			if (!reset) begin
				if (storeValid) begin
					checkStore(storeAddr, storeData);
				end
				if (halted && !haltSeen) begin
					checkHalt(haltPc);
					haltSeen = 1'b1;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD_NS);
		abortRun($sformatf("the core never halted within %0d clock cycles", WATCHDOG_CYCLES));
	end

endmodule

// File: verif/program_input.txt
# P <imem word index> <instruction>, S <dmem word index> <data> in store order
# H <expected halt pc>, all fields hex
P 00 20010007  # addi  r1, r0, 7
P 01 2002FFFD  # addi  r2, r0, -3
P 02 00221820  # add   r3, r1, r2
P 03 AC030000  # sw    r3, 0
P 04 00222023  # subu  r4, r1, r2
P 05 AC040001  # sw    r4, 1
P 06 00222824  # and   r5, r1, r2
P 07 00223025  # or    r6, r1, r2
P 08 00223826  # xor   r7, r1, r2
P 09 00204027  # nor   r8, r1, r0
P 0A AC050002  # sw    r5, 2
P 0B AC060003  # sw    r6, 3
P 0C AC070004  # sw    r7, 4
P 0D AC080005  # sw    r8, 5
P 0E 0041482A  # slt   r9, r2, r1
P 0F 0041502B  # sltu  r10, r2, r1
P 10 AC090006  # sw    r9, 6
P 11 AC0A0007  # sw    r10, 7
P 12 00815804  # sllv  r11, r1, r4
P 13 00A26006  # srlv  r12, r2, r5
P 14 AC0B0008  # sw    r11, 8
P 15 AC0C0009  # sw    r12, 9
P 16 00426821  # addu  r13, r2, r2
P 17 00417022  # sub   r14, r2, r1
P 18 AC0D000A  # sw    r13, 10
P 19 AC0E000B  # sw    r14, 11
P 1A AC02000C  # sw    r2, 12
P 1B 304FFF0F  # andi  r15, r2, 0xff0f
P 1C 34108001  # ori   r16, r0, 0x8001
P 1D 38518000  # xori  r17, r2, 0x8000
P 1E 3C121234  # lui   r18, 0x1234
P 1F 28530005  # slti  r19, r2, 5
P 20 2C540005  # sltiu r20, r2, 5
P 21 AC0F000D  # sw    r15, 13
P 22 AC10000E  # sw    r16, 14
P 23 AC11000F  # sw    r17, 15
P 24 AC120010  # sw    r18, 16
P 25 AC130011  # sw    r19, 17
P 26 AC140012  # sw    r20, 18
P 27 8C150010  # lw    r21, 16
P 28 AC150013  # sw    r21, 19
P 29 10210001  # beq   r1, r1, +1 taken
P 2A AC01003C  # sw    r1, 60 skipped
P 2B 10220001  # beq   r1, r2, +1 not taken
P 2C AC010014  # sw    r1, 20
P 2D 14220001  # bne   r1, r2, +1 taken
P 2E AC01003D  # sw    r1, 61 skipped
P 2F 14210001  # bne   r1, r1, +1 not taken
P 30 AC020015  # sw    r2, 21
P 31 08000033  # j     0x33
P 32 AC01003E  # sw    r1, 62 skipped
P 33 0C000036  # jal   0x36
P 34 AC010017  # sw    r1, 23 after return
P 35 FC000000  # halt
P 36 AC1F0016  # sw    r31, 22
P 37 03E00008  # jr    r31
P 38 AC01003F  # sw    r1, 63 never reached
S 00 00000004
S 01 0000000A
S 02 00000005
S 03 FFFFFFFF
S 04 FFFFFFFA
S 05 FFFFFFF8
S 06 00000001
S 07 00000000
S 08 00001C00
S 09 07FFFFFF
S 0A FFFFFFFA
S 0B FFFFFFF6
S 0C FFFFFFFD
S 0D 0000FF0D
S 0E 00008001
S 0F FFFF7FFD
S 10 12340000
S 11 00000001
S 12 00000000
S 13 12340000
S 14 00000007
S 15 FFFFFFFD
S 16 00000034
S 17 00000007
H 35
